// ==== frame_dma_defs.svh ====
// ================================================
// Frame read-out engine shared constants
// Frame size, word width, sync stretch, APB map
// ================================================
`ifndef FRAME_DMA_DEFS_SVH
`define FRAME_DMA_DEFS_SVH

// Default frame geometry (720p)
`define FD_H_PIX         1280
`define FD_V_LINES       720

// DMA and frame-buffer word width in bits
`define FD_WORD_BITS     128

// Cycles that the read frame sync stays high after a session start
`define FD_FSYNC_STRETCH 31

// ================================================
// APB register offsets
// ================================================
`define FD_REG_CTRL      9'h000  // bit0 bgrx_en, bit1 pattern_en
`define FD_REG_STATUS    9'h004  // bit0 session_active, bit1 msi_pending

`endif

// ==== frame_dma_pkg.sv ====
// ================================================
// Frame read-out engine types
// Pixel, word, counter and APB vector types
// ================================================
`include "frame_dma_defs.svh"

package frame_dma_pkg;

	// ================================================
	// Pixel formats
	// ================================================

	// Packed pixel as stored in the frame buffer
	// Blue in 15:11, green in 10:5, red in 4:0
	typedef logic [15:0] pix565_t;

	// Expanded pixel, x byte on top then red, green, blue
	typedef logic [31:0] bgrx_t;

	// ================================================
	// Data path and control
	// ================================================

	typedef logic [`FD_WORD_BITS-1:0] dma_word_t;  // Eight 565 or four BGRX pixels
	typedef logic [17:0]              word_cnt_t;  // Enough for a 720p BGRX frame
	typedef logic [11:0]              bar_x_t;     // Pixel column

	// APB slave
	typedef logic [8:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

endpackage

// ==== frame_dma_csr.sv ====
// ================================================
// APB register slave for the read-out engine
// CTRL mode bits, STATUS and the MSI pending flag
// ================================================
`timescale 1ns/1ns
`include "frame_dma_defs.svh"

module frame_dma_csr (
	input  logic                    i_pclk_div2,
	input  logic                    i_core_rst_n,
	input  logic                    i_psel,
	input  logic                    i_penable,
	input  logic                    i_pwrite,
	input  frame_dma_pkg::apb_addr_t i_paddr,
	input  frame_dma_pkg::apb_data_t i_pwdata,
	input  logic                    i_session_active,
	input  logic                    i_frame_done,
	input  logic                    i_msi_en,
	input  logic                    i_msi_grant,
	output logic                    o_pready,
	output frame_dma_pkg::apb_data_t o_prdata,
	output logic                    o_bgrx_en,
	output logic                    o_pattern_en,
	output logic                    o_msi_req
);
	import frame_dma_pkg::*;

	logic       apb_access;
	logic [1:0] ctrl_q;       // {pattern_en, bgrx_en}
	logic       msi_pending;

	// No wait states, access phase completes at once
	assign apb_access = i_psel & i_penable;
	assign o_pready   = apb_access;

	// ================================================
	// CTRL register
	// ================================================
	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			ctrl_q <= 2'b00;
		end else if (apb_access && i_pwrite && (i_paddr == `FD_REG_CTRL)) begin
			ctrl_q <= i_pwdata[1:0];
		end
	end

	assign o_bgrx_en    = ctrl_q[0];
	assign o_pattern_en = ctrl_q[1];

	// Read mux, only live during a read access
	always_comb begin
		o_prdata = '0;
		if (apb_access && !i_pwrite) begin
			case (i_paddr)
				`FD_REG_CTRL:   o_prdata = apb_data_t'(ctrl_q);
				`FD_REG_STATUS: o_prdata = apb_data_t'({msi_pending, i_session_active});
				default:        o_prdata = '0;
			endcase
		end
	end

	// ================================================
	// MSI pending flag
	// ================================================
	// A frame-done in the same cycle as a grant keeps the flag set
	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			msi_pending <= 1'b0;
		end else begin
			if (i_msi_grant)
				msi_pending <= 1'b0;
			if (i_frame_done)
				msi_pending <= 1'b1;
		end
	end

	assign o_msi_req = msi_pending & i_msi_en;  // Host enable gates the request

endmodule

// ==== frame_read_session.sv ====
// ================================================
// Frame read session tracker
// Counts DMA words per frame and stretches read sync
// ================================================
`timescale 1ns/1ns
`include "frame_dma_defs.svh"

module frame_read_session #(
	parameter int H_PIX   = `FD_H_PIX,
	parameter int V_LINES = `FD_V_LINES
) (
	input  logic i_pclk_div2,
	input  logic i_core_rst_n,
	input  logic i_cmd_start,
	input  logic i_rd_clk_en,
	input  logic i_bgrx_en,
	output logic o_session_start,
	output logic o_session_active,
	output logic o_expand_phase,
	output logic o_rd_en,
	output logic o_rd_fsync
);
	import frame_dma_pkg::*;

	// Words per frame, BGRX doubles the data volume
	localparam word_cnt_t WORDS_565  = word_cnt_t'(H_PIX * V_LINES * 16 / `FD_WORD_BITS);
	localparam word_cnt_t WORDS_BGRX = word_cnt_t'(H_PIX * V_LINES * 32 / `FD_WORD_BITS);
	localparam int        STRETCH_W  = $clog2(`FD_FSYNC_STRETCH + 1);

	word_cnt_t            word_cnt;
	word_cnt_t            frame_words;
	logic                 session_active;
	logic                 expand_phase;
	logic [STRETCH_W-1:0] fsync_cnt;

	assign frame_words     = i_bgrx_en ? WORDS_BGRX : WORDS_565;
	assign o_session_start = i_cmd_start & ~session_active;  // Start ignored mid-session

	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			session_active <= 1'b0;
			word_cnt       <= '0;
			expand_phase   <= 1'b0;
			fsync_cnt      <= '0;
		end else if (o_session_start) begin
			session_active <= 1'b1;
			word_cnt       <= '0;
			expand_phase   <= 1'b0;
			fsync_cnt      <= STRETCH_W'(`FD_FSYNC_STRETCH);
		end else begin
			if (session_active && i_rd_clk_en) begin
				if (word_cnt == frame_words - word_cnt_t'(1)) begin
					word_cnt       <= '0;
					session_active <= 1'b0;  // Last word of the frame
				end else begin
					word_cnt <= word_cnt + word_cnt_t'(1);
				end
				if (i_bgrx_en)
					expand_phase <= ~expand_phase;
			end
			if (fsync_cnt != '0)
				fsync_cnt <= fsync_cnt - STRETCH_W'(1);
		end
	end

	assign o_session_active = session_active;
	assign o_expand_phase   = expand_phase;
	assign o_rd_fsync       = (fsync_cnt != '0);

	// One frame-buffer word feeds two BGRX words, fetch on the low half only
	assign o_rd_en = i_rd_clk_en & (~i_bgrx_en | ~expand_phase);

endmodule

// ==== bar_pattern_gen.sv ====
// ================================================
// Post-buffer colour bar generator
// Eight vertical bars indexed by the DMA word column
// ================================================
`timescale 1ns/1ns
`include "frame_dma_defs.svh"

module bar_pattern_gen #(
	parameter int H_PIX = `FD_H_PIX
) (
	input  logic                  i_pclk_div2,
	input  logic                  i_core_rst_n,
	input  logic                  i_session_start,
	input  logic                  i_rd_clk_en,
	input  logic                  i_bgrx_en,
	output frame_dma_pkg::pix565_t o_bar_pix
);
	import frame_dma_pkg::*;

	localparam bar_x_t LINE_WORDS_565  = bar_x_t'(H_PIX / 8);
	localparam bar_x_t LINE_WORDS_BGRX = bar_x_t'(H_PIX / 4);
	localparam bar_x_t BAR_W           = bar_x_t'(H_PIX / 8);  // Pixels per bar

	bar_x_t     word_x;
	bar_x_t     line_words;
	bar_x_t     pix_x;
	logic [2:0] bar_idx;

	assign line_words = i_bgrx_en ? LINE_WORDS_BGRX : LINE_WORDS_565;
	assign pix_x      = i_bgrx_en ? (word_x << 2) : (word_x << 3);  // First pixel of word

	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			word_x <= '0;
		end else if (i_session_start) begin
			word_x <= '0;
		end else if (i_rd_clk_en) begin
			if (word_x == line_words - bar_x_t'(1))
				word_x <= '0;                       // End of line
			else
				word_x <= word_x + bar_x_t'(1);
		end
	end

	// Comparator chain instead of a divide by the bar width
	always_comb begin
		bar_idx = 3'd0;
		for (int i = 1; i < 8; i++) begin
			if (pix_x >= bar_x_t'(i * BAR_W))
				bar_idx = 3'(i);
		end
	end

	always_comb begin
		case (bar_idx)
			3'd0:    o_bar_pix = 16'h001F;  // Red
			3'd1:    o_bar_pix = 16'h07E0;  // Green
			3'd2:    o_bar_pix = 16'hF800;  // Blue
			3'd3:    o_bar_pix = 16'h07FF;  // Yellow
			3'd4:    o_bar_pix = 16'hFFE0;  // Cyan
			3'd5:    o_bar_pix = 16'hF81F;  // Magenta
			3'd6:    o_bar_pix = 16'hFFFF;  // White
			default: o_bar_pix = 16'h0000;  // Black
		endcase
	end

endmodule

// ==== pixel_formatter.sv ====
// ================================================
// DMA pixel formatter
// RGB565 pass-through, BGRX expansion, pattern select
// ================================================
`timescale 1ns/1ns

module pixel_formatter (
	input  logic                    i_pclk_div2,
	input  logic                    i_core_rst_n,
	input  frame_dma_pkg::dma_word_t i_frame_rd_data,
	input  logic                    i_rd_en,
	input  logic                    i_expand_phase,
	input  logic                    i_bgrx_en,
	input  logic                    i_pattern_en,
	input  frame_dma_pkg::pix565_t   i_bar_pix,
	output frame_dma_pkg::dma_word_t o_mwr_data
);
	import frame_dma_pkg::*;

	dma_word_t hold_q;
	dma_word_t frame_data;
	dma_word_t pattern_data;

	// Widen by repeating the top bits into the new LSBs
	function automatic logic [7:0] exp5(input logic [4:0] v);
		return {v, v[4:2]};
	endfunction

	function automatic logic [7:0] exp6(input logic [5:0] v);
		return {v, v[5:4]};
	endfunction

	function automatic bgrx_t to_bgrx(input pix565_t p);
		return {8'h08, exp5(p[4:0]), exp6(p[10:5]), exp5(p[15:11])};
	endfunction

	// Four pixels of a word into one BGRX word, hi picks pixels 4 to 7
	function automatic dma_word_t pack4(input dma_word_t w, input logic hi);
		dma_word_t r;
		pix565_t   p;
		r = '0;
		for (int i = 0; i < 4; i++) begin
			p = w[16*(i + (hi ? 4 : 0)) +: 16];
			r[32*i +: 32] = to_bgrx(p);
		end
		return r;
	endfunction

	// Keeps the upper four pixels for the second BGRX half
	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n) begin
			hold_q <= '0;
		end else if (i_rd_en) begin
			hold_q <= i_frame_rd_data;
		end
	end

	// ================================================
	// Output select
	// ================================================
	assign frame_data = !i_bgrx_en     ? i_frame_rd_data :
	                    i_expand_phase ? pack4(hold_q, 1'b1) :
	                                     pack4(i_frame_rd_data, 1'b0);

	assign pattern_data = i_bgrx_en ? {4{to_bgrx(i_bar_pix)}} : {8{i_bar_pix}};

	assign o_mwr_data = i_pattern_en ? pattern_data : frame_data;

endmodule

// ==== frame_dma_top.sv ====
// ================================================
// Frame read-out engine top level
// Joins CSR, read session, test pattern and formatter
// ================================================
`timescale 1ns/1ns
`include "frame_dma_defs.svh"

module frame_dma_top #(
	parameter int H_PIX   = `FD_H_PIX,
	parameter int V_LINES = `FD_V_LINES
) (
	input  logic                    i_pclk_div2,
	input  logic                    i_core_rst_n,
	// APB slave
	input  logic                    i_psel,
	input  logic                    i_penable,
	input  logic                    i_pwrite,
	input  frame_dma_pkg::apb_addr_t i_paddr,
	input  frame_dma_pkg::apb_data_t i_pwdata,
	output logic                    o_pready,
	output frame_dma_pkg::apb_data_t o_prdata,
	// DMA write engine side
	input  logic                    i_cmd_start,
	input  logic                    i_rd_clk_en,
	output frame_dma_pkg::dma_word_t o_mwr_data,
	// Frame buffer side
	output logic                    o_rd_en,
	output logic                    o_rd_fsync,
	input  frame_dma_pkg::dma_word_t i_frame_rd_data,
	// MSI
	input  logic                    i_frame_done,
	input  logic                    i_msi_en,
	input  logic                    i_msi_grant,
	output logic                    o_msi_req
);
	import frame_dma_pkg::*;

	logic    bgrx_en;
	logic    pattern_en;
	logic    session_start;
	logic    session_active;
	logic    expand_phase;
	pix565_t bar_pix;

	frame_dma_csr csr_i (
		.i_pclk_div2      (i_pclk_div2),
		.i_core_rst_n     (i_core_rst_n),
		.i_psel           (i_psel),
		.i_penable        (i_penable),
		.i_pwrite         (i_pwrite),
		.i_paddr          (i_paddr),
		.i_pwdata         (i_pwdata),
		.i_session_active (session_active),
		.i_frame_done     (i_frame_done),
		.i_msi_en         (i_msi_en),
		.i_msi_grant      (i_msi_grant),
		.o_pready         (o_pready),
		.o_prdata         (o_prdata),
		.o_bgrx_en        (bgrx_en),
		.o_pattern_en     (pattern_en),
		.o_msi_req        (o_msi_req)
	);

	frame_read_session #(
		.H_PIX   (H_PIX),
		.V_LINES (V_LINES)
	) session_i (
		.i_pclk_div2      (i_pclk_div2),
		.i_core_rst_n     (i_core_rst_n),
		.i_cmd_start      (i_cmd_start),
		.i_rd_clk_en      (i_rd_clk_en),
		.i_bgrx_en        (bgrx_en),
		.o_session_start  (session_start),
		.o_session_active (session_active),
		.o_expand_phase   (expand_phase),
		.o_rd_en          (o_rd_en),
		.o_rd_fsync       (o_rd_fsync)
	);

	bar_pattern_gen #(
		.H_PIX (H_PIX)
	) bar_i (
		.i_pclk_div2     (i_pclk_div2),
		.i_core_rst_n    (i_core_rst_n),
		.i_session_start (session_start),
		.i_rd_clk_en     (i_rd_clk_en),
		.i_bgrx_en       (bgrx_en),
		.o_bar_pix       (bar_pix)
	);

	pixel_formatter fmt_i (
		.i_pclk_div2     (i_pclk_div2),
		.i_core_rst_n    (i_core_rst_n),
		.i_frame_rd_data (i_frame_rd_data),
		.i_rd_en         (o_rd_en),         // Hold follows the frame-buffer fetch
		.i_expand_phase  (expand_phase),
		.i_bgrx_en       (bgrx_en),
		.i_pattern_en    (pattern_en),
		.i_bar_pix       (bar_pix),
		.o_mwr_data      (o_mwr_data)
	);

endmodule

// ==== frame_dma_props.sv ====
// ================================================
// Bound checks on session and MSI rules
// ================================================
`timescale 1ns/1ns
`include "frame_dma_defs.svh"

module frame_dma_props (
	input logic i_pclk_div2,
	input logic i_core_rst_n,
	input logic i_session_start,
	input logic i_session_active,
	input logic i_rd_fsync,
	input logic i_msi_req,
	input logic i_msi_pending,
	input logic i_frame_done,
	input logic i_msi_grant
);
	int         fail_cnt = 0;
	logic [5:0] fsync_len;  // Consecutive high cycles of the read sync

	always_ff @(posedge i_pclk_div2 or negedge i_core_rst_n) begin
		if (!i_core_rst_n)
			fsync_len <= '0;
		else if (i_rd_fsync)
			fsync_len <= fsync_len + 6'd1;
		else
			fsync_len <= '0;
	end

	a_start: assert property (@(posedge i_pclk_div2) disable iff (!i_core_rst_n)
		$rose(i_session_active) |-> $past(i_session_start))
		else begin
			$error("session opened without a start");
			fail_cnt++;
		end

	a_fsync: assert property (@(posedge i_pclk_div2) disable iff (!i_core_rst_n)
		$fell(i_rd_fsync) |-> (fsync_len == 6'(`FD_FSYNC_STRETCH)))
		else begin
			$error("read sync length wrong");
			fail_cnt++;
		end

	// Request only from a flag set by frame-done and not yet granted
	a_msi: assert property (@(posedge i_pclk_div2) disable iff (!i_core_rst_n)
		i_msi_req |-> (i_msi_pending &&
			($past(i_frame_done) || ($past(i_msi_pending) && !$past(i_msi_grant)))))
		else begin
			$error("MSI request without a pending frame-done");
			fail_cnt++;
		end

endmodule

// Session side, MSI inputs unused
bind frame_read_session frame_dma_props session_props_i (
	.i_pclk_div2      (i_pclk_div2),
	.i_core_rst_n     (i_core_rst_n),
	.i_session_start  (o_session_start),
	.i_session_active (session_active),
	.i_rd_fsync       (o_rd_fsync),
	.i_msi_req        (1'b0),
	.i_msi_pending    (1'b0),
	.i_frame_done     (1'b0),
	.i_msi_grant      (1'b0)
);

// CSR side, session inputs unused
bind frame_dma_csr frame_dma_props csr_props_i (
	.i_pclk_div2      (i_pclk_div2),
	.i_core_rst_n     (i_core_rst_n),
	.i_session_start  (1'b0),
	.i_session_active (1'b0),
	.i_rd_fsync       (1'b0),
	.i_msi_req        (o_msi_req),
	.i_msi_pending    (msi_pending),
	.i_frame_done     (i_frame_done),
	.i_msi_grant      (i_msi_grant)
);

// ==== tb_frame_dma.sv ====
// ================================================
// Testbench for the frame read-out engine
// Frame buffer model, reference checker, APB and MSI
// ================================================
`timescale 1ns/1ns
`include "frame_dma_defs.svh"

module tb_frame_dma;
	import frame_dma_pkg::*;

	localparam int H_PIX      = 32;
	localparam int V_LINES    = 4;
	localparam int WORDS_565  = H_PIX * V_LINES * 16 / `FD_WORD_BITS;
	localparam int WORDS_BGRX = 2 * WORDS_565;
	// At most four cycles a word, plus APB, sync wait and MSI steps
	localparam int LIMIT_CYCLES = 4 * (2 * WORDS_565 + 2 * WORDS_BGRX) + 4 * 60 + 200;

	logic      pclk_div2;
	logic      core_rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	logic      pready;
	apb_data_t prdata;
	logic      cmd_start;
	logic      rd_clk_en;
	dma_word_t mwr_data;
	logic      rd_en;
	logic      rd_fsync;
	dma_word_t frame_rd_data;
	logic      frame_done;
	logic      msi_en;
	logic      msi_grant;
	logic      msi_req;

	logic [15:0] data_lfsr = 16'd27;
	logic [15:0] gap_lfsr  = 16'd27;

	// Reference model state
	logic      mode_bgrx  = 1'b0;
	logic      mode_pat   = 1'b0;
	logic      ref_active = 1'b0;
	logic      ref_phase  = 1'b0;
	int        ref_words  = 0;
	int        ref_col    = 0;
	int        fsync_left = 0;
	dma_word_t ref_held   = '0;

	frame_dma_top #(
		.H_PIX   (H_PIX),
		.V_LINES (V_LINES)
	) dut_i (
		.i_pclk_div2     (pclk_div2),
		.i_core_rst_n    (core_rst_n),
		.i_psel          (psel),
		.i_penable       (penable),
		.i_pwrite        (pwrite),
		.i_paddr         (paddr),
		.i_pwdata        (pwdata),
		.o_pready        (pready),
		.o_prdata        (prdata),
		.i_cmd_start     (cmd_start),
		.i_rd_clk_en     (rd_clk_en),
		.o_mwr_data      (mwr_data),
		.o_rd_en         (rd_en),
		.o_rd_fsync      (rd_fsync),
		.i_frame_rd_data (frame_rd_data),
		.i_frame_done    (frame_done),
		.i_msi_en        (msi_en),
		.i_msi_grant     (msi_grant),
		.o_msi_req       (msi_req)
	);

	initial begin
		pclk_div2 = 1'b0;
		forever #5 pclk_div2 = ~pclk_div2;
	end

	// ================================================
	// Random bits, reference rules, compare tasks
	// ================================================
	// Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit
	function automatic dma_word_t take_bits(inout logic [15:0] st, input int n);
		dma_word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			st = {st[14:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
			r  = {r[126:0], st[0]};
		end
		return r;
	endfunction

	function automatic bgrx_t expand_pix(input pix565_t p);
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
		r = p[4:0];
		g = p[10:5];
		b = p[15:11];
		return {8'h08, r, r[4:2], g, g[5:4], b, b[4:2]};
	endfunction

	function automatic pix565_t bar_colour(input int col, input logic bgrx);
		int px;
		px = bgrx ? col * 4 : col * 8;  // First pixel of the word
		case (px / (H_PIX / 8))
			0:       return 16'h001F;
			1:       return 16'h07E0;
			2:       return 16'hF800;
			3:       return 16'h07FF;
			4:       return 16'hFFE0;
			5:       return 16'hF81F;
			6:       return 16'hFFFF;
			default: return 16'h0000;
		endcase
	endfunction

	function automatic dma_word_t expected_word(input dma_word_t live, input dma_word_t held,
			input logic bgrx, input logic pat, input logic ph, input int col);
		dma_word_t r;
		pix565_t   bp;
		pix565_t   p;
		bp = bar_colour(col, bgrx);
		r  = pat ? {8{bp}} : live;
		if (bgrx) begin
			for (int i = 0; i < 4; i++) begin
				p = pat ? bp : (ph ? held[16*(i+4) +: 16] : live[16*i +: 16]);
				r[32*i +: 32] = expand_pix(p);
			end
		end
		return r;
	endfunction

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input dma_word_t got, input dma_word_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_apb(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_logic(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// ================================================
	// Frame buffer model and reference checker
	// ================================================
	initial begin
		frame_rd_data = take_bits(data_lfsr, `FD_WORD_BITS);
		forever begin
			@(posedge pclk_div2);
			if (rd_en)
				frame_rd_data <= take_bits(data_lfsr, `FD_WORD_BITS);  // Advance after fetch
		end
	end

	always @(posedge pclk_div2) begin
		int line_words;
		int frame_words;
		line_words  = mode_bgrx ? H_PIX / 4 : H_PIX / 8;
		frame_words = mode_bgrx ? WORDS_BGRX : WORDS_565;
		if (core_rst_n) begin
			check_logic("o_rd_fsync", rd_fsync, fsync_left != 0);
			check_logic("o_rd_en", rd_en, rd_clk_en && (!mode_bgrx || !ref_phase));
			if (rd_clk_en)
				check_word("o_mwr_data", mwr_data, expected_word(frame_rd_data, ref_held,
					mode_bgrx, mode_pat, ref_phase, ref_col));
			if (rd_clk_en && (!mode_bgrx || !ref_phase))
				ref_held = frame_rd_data;
			if (cmd_start && !ref_active) begin
				ref_active = 1'b1;
				ref_words  = 0;
				ref_phase  = 1'b0;
				ref_col    = 0;
				fsync_left = `FD_FSYNC_STRETCH;
			end else begin
				if (fsync_left != 0)
					fsync_left--;
				if (rd_clk_en) begin
					ref_col = (ref_col == line_words - 1) ? 0 : ref_col + 1;
					if (ref_active) begin
						if (mode_bgrx)
							ref_phase = !ref_phase;
						if (ref_words == frame_words - 1)
							ref_active = 1'b0;  // Frame complete
						ref_words++;
					end
				end
			end
		end
	end

	// ================================================
	// Stimulus tasks
	// ================================================
	task automatic apb_write(input apb_addr_t a, input apb_data_t d);
		@(posedge pclk_div2);
		psel    <= 1'b1;
		pwrite  <= 1'b1;
		paddr   <= a;
		pwdata  <= d;
		@(posedge pclk_div2);
		penable <= 1'b1;
		@(posedge pclk_div2);
		check_logic("o_pready", pready, 1'b1);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read_check(input apb_addr_t a, input apb_data_t exp);
		@(posedge pclk_div2);
		psel    <= 1'b1;
		paddr   <= a;
		@(posedge pclk_div2);
		penable <= 1'b1;
		@(posedge pclk_div2);
		check_logic("o_pready", pready, 1'b1);
		check_apb("o_prdata", prdata, exp);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// One session with gapped strobes, poke repeats the start mid-frame
	task automatic run_frame(input logic bgrx, input logic pat, input logic poke);
		int n;
		int gap;
		n = bgrx ? WORDS_BGRX : WORDS_565;
		apb_write(`FD_REG_CTRL, {30'd0, pat, bgrx});
		mode_bgrx <= bgrx;
		mode_pat  <= pat;
		@(posedge pclk_div2);
		cmd_start <= 1'b1;
		@(posedge pclk_div2);
		cmd_start <= 1'b0;
		apb_read_check(`FD_REG_STATUS, 32'h1);
		for (int i = 0; i < n; i++) begin
			@(posedge pclk_div2);
			rd_clk_en <= 1'b1;
			cmd_start <= poke && (i == n / 2);
			gap = int'(take_bits(gap_lfsr, 2));
			repeat (gap) begin
				@(posedge pclk_div2);
				rd_clk_en <= 1'b0;
				cmd_start <= 1'b0;
			end
		end
		@(posedge pclk_div2);
		rd_clk_en <= 1'b0;
		cmd_start <= 1'b0;
		apb_read_check(`FD_REG_STATUS, 32'h0);  // Closed right after the last word
		while (rd_fsync)
			@(posedge pclk_div2);
	endtask

	task automatic expect_req(input logic exp);
		@(posedge pclk_div2);
		check_logic("o_msi_req", msi_req, exp);
	endtask

	// ================================================
	// Test sequence
	// ================================================
	initial begin
		core_rst_n = 1'b0;
		psel       <= 1'b0;
		penable    <= 1'b0;
		pwrite     <= 1'b0;
		paddr      <= '0;
		pwdata     <= '0;
		cmd_start  <= 1'b0;
		rd_clk_en  <= 1'b0;
		frame_done <= 1'b0;
		msi_en     <= 1'b0;
		msi_grant  <= 1'b0;
		repeat (2) @(posedge pclk_div2);
		core_rst_n <= 1'b1;
		@(posedge pclk_div2);
		check_logic("o_msi_req", msi_req, 1'b0);
		check_logic("o_rd_fsync", rd_fsync, 1'b0);
		check_logic("o_rd_en", rd_en, 1'b0);
		check_logic("o_pready", pready, 1'b0);

		// Register map
		apb_read_check(`FD_REG_CTRL, 32'h0);
		apb_write(`FD_REG_CTRL, 32'hFFFF_FFFF);
		apb_read_check(`FD_REG_CTRL, 32'h3);
		apb_read_check(`FD_REG_STATUS, 32'h0);
		apb_read_check(9'h008, 32'h0);
		apb_read_check(9'h1FC, 32'h0);
		apb_write(`FD_REG_CTRL, 32'h0);

		run_frame(1'b0, 1'b0, 1'b1);  // RGB565
		run_frame(1'b1, 1'b0, 1'b0);  // BGRX
		run_frame(1'b0, 1'b1, 1'b0);  // Bars, RGB565
		run_frame(1'b1, 1'b1, 1'b0);  // Bars, BGRX

		// MSI with the host enable set
		msi_en <= 1'b1;
		@(posedge pclk_div2);
		frame_done <= 1'b1;
		@(posedge pclk_div2);
		frame_done <= 1'b0;
		check_logic("o_msi_req", msi_req, 1'b0);
		expect_req(1'b1);
		apb_read_check(`FD_REG_STATUS, 32'h2);
		@(posedge pclk_div2);
		msi_grant <= 1'b1;
		@(posedge pclk_div2);
		msi_grant <= 1'b0;
		expect_req(1'b0);

		// Enable low holds the request back, pending stays visible
		msi_en <= 1'b0;
		@(posedge pclk_div2);
		frame_done <= 1'b1;
		@(posedge pclk_div2);
		frame_done <= 1'b0;
		expect_req(1'b0);
		apb_read_check(`FD_REG_STATUS, 32'h2);
		msi_en <= 1'b1;
		expect_req(1'b1);
		msi_grant <= 1'b1;
		@(posedge pclk_div2);
		msi_grant <= 1'b0;
		expect_req(1'b0);
		apb_read_check(`FD_REG_STATUS, 32'h0);

		repeat (2) @(posedge pclk_div2);
		if (dut_i.session_i.session_props_i.fail_cnt + dut_i.csr_i.csr_props_i.fail_cnt == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

	initial begin
		#(LIMIT_CYCLES * 10);
		$display("watchdog timeout, the tests did not finish in time");
		abort_run();
	end

endmodule

// ==== frame_dma.f ====
+incdir+.
frame_dma_pkg.sv
frame_dma_csr.sv
frame_read_session.sv
bar_pattern_gen.sv
pixel_formatter.sv
frame_dma_top.sv
frame_dma_props.sv
tb_frame_dma.sv

// ==== Bender.yml ====
package:
  name: frame_dma

sources:
  - include_dirs:
      - .
    files:
      - frame_dma_pkg.sv
      - frame_dma_csr.sv
      - frame_read_session.sv
      - bar_pattern_gen.sv
      - pixel_formatter.sv
      - frame_dma_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - frame_dma_props.sv
      - tb_frame_dma.sv
